// ==== Makefile ====
# Verilator build for the flow table host interface
VERILATOR ?= verilator
FILELIST  ?= flow_host_inf.f
RTL_TOP   ?= flow_host_inf
TB_TOP    ?= flow_host_inf_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(BUILD_DIR) -o $(TB_TOP)
	-./$(BUILD_DIR)/$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q -F "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== common/flow_host_cfg.svh ====
`ifndef FLOW_HOST_CFG_SVH
`define FLOW_HOST_CFG_SVH

// bus and field widths
`define FH_DATA_W          32
`define FH_ADDR_W          32
`define FH_LOCAL_ADDR_W    8
`define FH_TBL_W           16
`define FH_MATCH_W         256
`define FH_ACTION_W        320
`define FH_STATS_W         64

// returned for unmapped reads
`define FH_FILL_WORD       32'hBEEF_CAFE

// register word addresses
`define FH_REG_BASE_ADDR        8'h00
`define FH_REG_WRITE_ORDER      8'h01
`define FH_REG_MOD_WRITE_ORDER  8'h02
`define FH_REG_READ_ORDER       8'h03
`define FH_REG_ACC_RDY          8'h04
`define FH_REG_EXACT_HIT        8'h05
`define FH_REG_EXACT_MISS       8'h06
`define FH_REG_WILDCARD_HIT     8'h07
`define FH_REG_WILDCARD_MISS    8'h08
`define FH_REG_ENTRY_BASE       8'h10

`endif

// ==== common/flow_host_pkg.sv ====
`include "flow_host_cfg.svh"

package flow_host_pkg;

   typedef logic [`FH_DATA_W-1:0] axi_data_t;

   typedef enum logic [1:0] {
      RESP_OKAY   = 2'b00,
      RESP_SLVERR = 2'b10
   } axi_resp_e;

   typedef logic [`FH_LOCAL_ADDR_W-1:0] local_addr_t;
   typedef logic [`FH_TBL_W-1:0]        tbl_addr_t;

   typedef logic [`FH_MATCH_W-1:0]  match_t;
   typedef logic [`FH_ACTION_W-1:0] action_t;
   typedef logic [`FH_STATS_W-1:0]  stats_t;

   // kind of flow table access
   typedef enum logic [1:0] {
      CMD_WRITE     = 2'd0,
      CMD_MOD_WRITE = 2'd1,
      CMD_READ      = 2'd2
   } entry_cmd_e;

   typedef logic [4:0] entry_idx_t;

   // entry layout is match, mask, action, stats
   localparam int MATCH_WORDS      = `FH_MATCH_W / `FH_DATA_W;
   localparam int ACTION_WORDS     = `FH_ACTION_W / `FH_DATA_W;
   localparam int STATS_WORDS      = `FH_STATS_W / `FH_DATA_W;
   localparam int ENTRY_WORDS      = 2 * MATCH_WORDS + ACTION_WORDS + STATS_WORDS;
   localparam int STATS_FIRST_WORD = 2 * MATCH_WORDS + ACTION_WORDS;

endpackage

// ==== common/reg_wr_if.sv ====
`timescale 1ns/10ps

interface reg_wr_if
   import flow_host_pkg::*;
();

   // one-cycle strobes, no back-pressure
   logic       base_vld;
   logic       entry_vld;
   entry_idx_t entry_idx;
   axi_data_t  data;
   logic       cmd_vld;
   entry_cmd_e cmd;

   modport decoder (output base_vld, entry_vld, entry_idx, data, cmd_vld, cmd);

   modport stage (input base_vld, entry_vld, entry_idx, data);

   modport access (input cmd_vld, cmd);

endinterface

// ==== flow_host_inf.f ====
+incdir+common
common/flow_host_pkg.sv
common/reg_wr_if.sv
host_inf/axil_write_decoder.sv
host_inf/flow_entry_stage.sv
host_inf/flow_table_access.sv
host_inf/axil_read_mux.sv
verilog/flow_host_inf.sv
tests/flow_table_model.sv
tests/flow_host_inf_tb.sv

// ==== host_inf/axil_read_mux.sv ====
`timescale 1ns/10ps
`include "flow_host_cfg.svh"

module axil_read_mux
   import flow_host_pkg::*;
(
   input  logic                  aclk,
   input  logic                  aresetn,
   input  logic [`FH_ADDR_W-1:0] araddr,
   input  logic                  arvalid,
   output logic                  arready,
   output axi_data_t             rdata,
   output axi_resp_e             rresp,
   output logic                  rvalid,
   input  logic                  rready,
   input  axi_data_t             exact_hit,
   input  axi_data_t             exact_miss,
   input  axi_data_t             wildcard_hit,
   input  axi_data_t             wildcard_miss,
   input  tbl_addr_t             tbl_addr,
   input  logic                  acc_rdy,
   input  stats_t                stats_rd
);

   typedef enum logic [1:0] {
      RD_IDLE,
      RD_WAIT,
      RD_RESP
   } rd_state_e;

   localparam local_addr_t ENTRY_END  = local_addr_t'(`FH_REG_ENTRY_BASE + ENTRY_WORDS);
   localparam local_addr_t STATS_ADDR = local_addr_t'(`FH_REG_ENTRY_BASE + STATS_FIRST_WORD);

   rd_state_e                        state;
   local_addr_t                      rd_addr;
   axi_data_t                        rd_word;
   logic [$clog2(STATS_WORDS)-1:0]   stats_word;

   assign arready    = (state == RD_IDLE);
   assign rvalid     = (state == RD_RESP);
   assign rresp      = RESP_OKAY;
   assign stats_word = $bits(stats_word)'(rd_addr - STATS_ADDR);

   // register map
   always_comb begin
      rd_word = `FH_FILL_WORD;
      if (rd_addr < `FH_REG_ENTRY_BASE) begin
         case (rd_addr)
            `FH_REG_BASE_ADDR:     rd_word = {{(`FH_DATA_W-`FH_TBL_W){1'b0}}, tbl_addr};
            `FH_REG_ACC_RDY:       rd_word = {{(`FH_DATA_W-1){1'b0}}, acc_rdy};
            `FH_REG_EXACT_HIT:     rd_word = exact_hit;
            `FH_REG_EXACT_MISS:    rd_word = exact_miss;
            `FH_REG_WILDCARD_HIT:  rd_word = wildcard_hit;
            `FH_REG_WILDCARD_MISS: rd_word = wildcard_miss;
            default:               rd_word = `FH_FILL_WORD;
         endcase
      end
      else if (rd_addr < ENTRY_END) begin
         // only the stats part of the entry reads back, low word first
         if (rd_addr >= STATS_ADDR) rd_word = stats_rd[stats_word*`FH_DATA_W +: `FH_DATA_W];
         else rd_word = '0;
      end
   end

   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         state <= RD_IDLE;
      end
      else begin
         case (state)
            RD_IDLE: begin
               if (arvalid) state <= RD_WAIT;
            end
            RD_WAIT: state <= RD_RESP;
            default: begin
               if (rready) state <= RD_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge aclk) begin
      if (arready && arvalid) rd_addr <= araddr[`FH_LOCAL_ADDR_W-1:0];
   end

   // sampled once so rdata holds while rvalid waits on rready
   always_ff @(posedge aclk) begin
      if (state == RD_WAIT) rdata <= rd_word;
   end

endmodule

// ==== host_inf/axil_write_decoder.sv ====
`timescale 1ns/10ps
`include "flow_host_cfg.svh"

module axil_write_decoder
   import flow_host_pkg::*;
(
   input  logic                    aclk,
   input  logic                    aresetn,
   input  logic [`FH_ADDR_W-1:0]   awaddr,
   input  logic                    awvalid,
   output logic                    awready,
   input  axi_data_t               wdata,
   // byte strobes ignored, every write is a full word
   input  logic [`FH_DATA_W/8-1:0] wstrb,
   input  logic                    wvalid,
   output logic                    wready,
   output axi_resp_e               bresp,
   output logic                    bvalid,
   input  logic                    bready,
   reg_wr_if.decoder               wr
);

   typedef enum logic [1:0] {
      WR_IDLE,
      WR_DATA,
      WR_RESP
   } wr_state_e;

   localparam local_addr_t ENTRY_END = local_addr_t'(`FH_REG_ENTRY_BASE + ENTRY_WORDS);

   wr_state_e   state;
   local_addr_t wr_addr;
   logic        w_hs;
   logic        in_entry;
   logic        is_order;
   entry_cmd_e  order_cmd;

   assign awready  = (state == WR_IDLE);
   assign wready   = (state == WR_DATA);
   assign bvalid   = (state == WR_RESP);
   assign w_hs     = wready && wvalid;
   assign in_entry = (wr_addr >= `FH_REG_ENTRY_BASE) && (wr_addr < ENTRY_END);

   always_comb begin
      is_order  = 1'b1;
      order_cmd = CMD_WRITE;
      case (wr_addr)
         `FH_REG_WRITE_ORDER:     order_cmd = CMD_WRITE;
         `FH_REG_MOD_WRITE_ORDER: order_cmd = CMD_MOD_WRITE;
         `FH_REG_READ_ORDER:      order_cmd = CMD_READ;
         default:                 is_order  = 1'b0;
      endcase
   end

   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         state <= WR_IDLE;
         bresp <= RESP_OKAY;
      end
      else begin
         case (state)
            WR_IDLE: begin
               if (awvalid) state <= WR_DATA;
            end
            WR_DATA: begin
               if (wvalid) begin
                  state <= WR_RESP;
                  bresp <= (wr_addr < ENTRY_END) ? RESP_OKAY : RESP_SLVERR;
               end
            end
            default: begin
               if (bready) state <= WR_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge aclk) begin
      if (awready && awvalid) wr_addr <= awaddr[`FH_LOCAL_ADDR_W-1:0];
   end

   // decoded effects show up the cycle after the W handshake
   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         wr.base_vld  <= 1'b0;
         wr.entry_vld <= 1'b0;
         wr.cmd_vld   <= 1'b0;
      end
      else begin
         wr.base_vld  <= w_hs && (wr_addr == `FH_REG_BASE_ADDR);
         wr.entry_vld <= w_hs && in_entry;
         wr.cmd_vld   <= w_hs && is_order;
      end
   end

   always_ff @(posedge aclk) begin
      if (w_hs) begin
         wr.data      <= wdata;
         wr.entry_idx <= entry_idx_t'(wr_addr - `FH_REG_ENTRY_BASE);
         wr.cmd       <= order_cmd;
      end
   end

endmodule

// ==== host_inf/flow_entry_stage.sv ====
`timescale 1ns/10ps
`include "flow_host_cfg.svh"

module flow_entry_stage
   import flow_host_pkg::*;
(
   input  logic      aclk,
   input  logic      aresetn,
   reg_wr_if.stage   wr,
   input  logic      wr_done,
   output tbl_addr_t flow_entry_addr,
   output match_t    flow_entry_match,
   output match_t    flow_entry_mask,
   output action_t   flow_entry_action,
   output stats_t    flow_entry_stats
);

   axi_data_t entry_buf [ENTRY_WORDS];

   always_ff @(posedge aclk) begin
      if (!aresetn) flow_entry_addr <= '0;
      else if (wr.base_vld) flow_entry_addr <= wr.data[`FH_TBL_W-1:0];
   end

   // staged entry is wiped once the table has taken it
   always_ff @(posedge aclk) begin
      if (!aresetn || wr_done) begin
         for (int i = 0; i < ENTRY_WORDS; i++) entry_buf[i] <= '0;
      end
      else if (wr.entry_vld) begin
         entry_buf[wr.entry_idx] <= wr.data;
      end
   end

   for (genvar i = 0; i < MATCH_WORDS; i++) begin : g_match
      assign flow_entry_match[i*`FH_DATA_W +: `FH_DATA_W] = entry_buf[i];
      assign flow_entry_mask[i*`FH_DATA_W +: `FH_DATA_W]  = entry_buf[MATCH_WORDS + i];
   end

   for (genvar i = 0; i < ACTION_WORDS; i++) begin : g_action
      assign flow_entry_action[i*`FH_DATA_W +: `FH_DATA_W] = entry_buf[2*MATCH_WORDS + i];
   end

   for (genvar i = 0; i < STATS_WORDS; i++) begin : g_stats
      assign flow_entry_stats[i*`FH_DATA_W +: `FH_DATA_W] = entry_buf[STATS_FIRST_WORD + i];
   end

endmodule

// ==== host_inf/flow_table_access.sv ====
`timescale 1ns/10ps

module flow_table_access
   import flow_host_pkg::*;
(
   input  logic      aclk,
   input  logic      aresetn,
   reg_wr_if.access  cmd,
   input  logic      flow_entry_ack,
   input  logic      flow_entry_done,
   input  stats_t    flow_entry_stats_in,
   output logic      flow_entry_req,
   output logic      flow_entry_wr,
   output logic      flow_entry_stats_en,
   output logic      wr_done,
   output logic      acc_rdy,
   output stats_t    stats_rd
);

   typedef enum logic [1:0] {
      ACC_IDLE,
      ACC_WAIT_WR,
      ACC_WAIT_RD
   } acc_state_e;

   acc_state_e state;

   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         state               <= ACC_IDLE;
         flow_entry_req      <= 1'b0;
         flow_entry_wr       <= 1'b0;
         flow_entry_stats_en <= 1'b0;
         wr_done             <= 1'b0;
         acc_rdy             <= 1'b1;
      end
      else begin
         wr_done <= 1'b0;
         case (state)
            // orders only taken here, anything while busy is dropped
            ACC_IDLE: begin
               if (cmd.cmd_vld) begin
                  flow_entry_req <= 1'b1;
                  acc_rdy        <= 1'b0;
                  case (cmd.cmd)
                     CMD_WRITE: begin
                        flow_entry_wr       <= 1'b1;
                        flow_entry_stats_en <= 1'b1;
                        state               <= ACC_WAIT_WR;
                     end
                     CMD_MOD_WRITE: begin
                        // keep stored stats
                        flow_entry_wr       <= 1'b1;
                        flow_entry_stats_en <= 1'b0;
                        state               <= ACC_WAIT_WR;
                     end
                     default: begin
                        flow_entry_wr       <= 1'b0;
                        flow_entry_stats_en <= 1'b1;
                        state               <= ACC_WAIT_RD;
                     end
                  endcase
               end
            end
            ACC_WAIT_WR, ACC_WAIT_RD: begin
               if (flow_entry_ack) flow_entry_req <= 1'b0;
               if (flow_entry_done) begin
                  flow_entry_req <= 1'b0;
                  acc_rdy        <= 1'b1;
                  wr_done        <= (state == ACC_WAIT_WR);
                  state          <= ACC_IDLE;
               end
            end
            default: state <= ACC_IDLE;
         endcase
      end
   end

   // stats from the table are valid in the done cycle
   always_ff @(posedge aclk) begin
      if (!aresetn) stats_rd <= '0;
      else if ((state == ACC_WAIT_RD) && flow_entry_done) stats_rd <= flow_entry_stats_in;
   end

endmodule

// ==== tests/flow_host_inf_tb.sv ====
`timescale 1ns/10ps
`include "flow_host_cfg.svh"

module flow_host_inf_tb
   import flow_host_pkg::*;
();

   localparam int        HS_LIMIT      = 100;
   localparam int        POLL_LIMIT    = 50;
   localparam logic [7:0] FULL_SEED    = 8'h3C;
   localparam logic [7:0] MATCH_SEED   = 8'h5A;
   localparam axi_data_t EXACT_HIT_VAL = 32'h0000_1A2B;
   localparam axi_data_t EXACT_MISS_VAL = 32'h0003_0C4D;
   localparam axi_data_t WILD_HIT_VAL  = 32'h0050_6E0F;
   localparam axi_data_t WILD_MISS_VAL = 32'h0700_8091;

   typedef enum logic [2:0] {OP_WRITE, OP_READ, OP_WAIT_RDY, OP_CHECK_REQ} op_e;
   typedef enum logic [1:0] {FILL_ZERO, FILL_MATCH, FILL_FULL} fill_e;

   // addr is the table address and data[7:0] the pattern seed on request checks
   typedef struct packed {
      op_e         op;
      logic [31:0] addr;
      axi_data_t   data;
      axi_resp_e   resp;
      fill_e       fill;
      logic        exp_wr;
      logic        exp_stats_en;
      int          count;
   } step_t;

   step_t steps[$];

   logic                    aclk = 1'b0;
   logic                    aresetn;
   logic [`FH_ADDR_W-1:0]   awaddr;
   logic                    awvalid;
   logic                    awready;
   axi_data_t               wdata;
   logic [`FH_DATA_W/8-1:0] wstrb;
   logic                    wvalid;
   logic                    wready;
   axi_resp_e               bresp;
   logic                    bvalid;
   logic                    bready;
   logic [`FH_ADDR_W-1:0]   araddr;
   logic                    arvalid;
   logic                    arready;
   axi_data_t               rdata;
   axi_resp_e               rresp;
   logic                    rvalid;
   logic                    rready;
   tbl_addr_t               flow_entry_addr;
   match_t                  flow_entry_match;
   match_t                  flow_entry_mask;
   action_t                 flow_entry_action;
   stats_t                  flow_entry_stats;
   stats_t                  flow_entry_stats_in;
   logic                    flow_entry_wr;
   logic                    flow_entry_stats_en;
   logic                    flow_entry_req;
   logic                    flow_entry_ack;
   logic                    flow_entry_done;
   axi_data_t               exact_hit;
   axi_data_t               exact_miss;
   axi_data_t               wildcard_hit;
   axi_data_t               wildcard_miss;
   int                      req_count;
   tbl_addr_t               req_addr;
   match_t                  req_match;
   match_t                  req_mask;
   action_t                 req_action;
   stats_t                  req_stats;
   logic                    req_wr;
   logic                    req_stats_en;

   always #10 aclk = ~aclk;

   flow_host_inf flow_host_inf_inst (.*);

   flow_table_model flow_table_model_inst (.*);

   task automatic fail_run(input string reason);
      $display("%s", reason);
      $display("*** TEST FAILED ***");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic next_cycle(inout int count, input int limit, input string what);
      @(negedge aclk);
      count++;
      if (count > limit) fail_run($sformatf("timed out waiting for %s", what));
   endtask

   task automatic compare_word(input axi_data_t got, input axi_data_t exp, input string what);
      if (got !== exp)
         fail_run($sformatf("Mismatch at %0t: %s read %h, expected %h", $time, what, got, exp));
   endtask

   task automatic verify_resp(input axi_resp_e got, input axi_resp_e exp, input string what);
      if (got !== exp)
         fail_run($sformatf("Mismatch at %0t: %s answered %s, expected %s",
                            $time, what, got.name(), exp.name()));
   endtask

   task automatic inspect_request(input tbl_addr_t exp_addr, input match_t exp_match,
                                  input match_t exp_mask, input action_t exp_action,
                                  input stats_t exp_stats, input logic exp_wr,
                                  input logic exp_stats_en);
      if (req_addr !== exp_addr)
         fail_run($sformatf("Mismatch at %0t: request address %h, expected %h",
                            $time, req_addr, exp_addr));
      if (req_match !== exp_match)
         fail_run($sformatf("Mismatch at %0t: request match %h", $time, req_match));
      if (req_mask !== exp_mask)
         fail_run($sformatf("Mismatch at %0t: request mask %h", $time, req_mask));
      if (req_action !== exp_action)
         fail_run($sformatf("Mismatch at %0t: request action %h", $time, req_action));
      if (req_stats !== exp_stats)
         fail_run($sformatf("Mismatch at %0t: request stats %h, expected %h",
                            $time, req_stats, exp_stats));
      if ({req_wr, req_stats_en} !== {exp_wr, exp_stats_en})
         fail_run($sformatf("Mismatch at %0t: wr/stats_en %b%b, expected %b%b",
                            $time, req_wr, req_stats_en, exp_wr, exp_stats_en));
   endtask

   // all bus tasks start and end on a falling edge
   task automatic write_register(input logic [31:0] addr, input axi_data_t data,
                                 output axi_resp_e resp);
      int cnt;
      awaddr  = addr;
      awvalid = 1'b1;
      wdata   = data;
      cnt     = 0;
      while (!awready) next_cycle(cnt, HS_LIMIT, "awready");
      @(negedge aclk);
      awvalid = 1'b0;
      wvalid  = 1'b1;
      cnt     = 0;
      while (!wready) next_cycle(cnt, HS_LIMIT, "wready");
      @(negedge aclk);
      wvalid = 1'b0;
      bready = 1'b1;
      cnt    = 0;
      while (!bvalid) next_cycle(cnt, HS_LIMIT, "bvalid");
      resp = bresp;
      @(negedge aclk);
      bready = 1'b0;
   endtask

   task automatic read_register(input logic [31:0] addr, output axi_data_t data,
                                output axi_resp_e resp);
      int cnt;
      araddr  = addr;
      arvalid = 1'b1;
      cnt     = 0;
      while (!arready) next_cycle(cnt, HS_LIMIT, "arready");
      @(negedge aclk);
      arvalid = 1'b0;
      rready  = 1'b1;
      cnt     = 0;
      while (!rvalid) next_cycle(cnt, HS_LIMIT, "rvalid");
      data = rdata;
      resp = rresp;
      @(negedge aclk);
      rready = 1'b0;
   endtask

   task automatic wait_until_ready();
      axi_data_t word;
      axi_resp_e resp;
      int        polls;
      polls = 0;
      word  = '0;
      while (word[0] !== 1'b1) begin
         if (polls == POLL_LIMIT) fail_run("access ready flag never came back to 1");
         polls++;
         read_register(32'h04, word, resp);
         verify_resp(resp, RESP_OKAY, "acc_rdy poll");
      end
   endtask

   task automatic await_request(input int count);
      int cnt;
      cnt = 0;
      while (req_count < count) next_cycle(cnt, HS_LIMIT, "a flow table request");
   endtask

   // word pattern covers every bit of the word index
   function automatic axi_data_t entry_word(input logic [7:0] seed, input entry_idx_t idx);
      return {seed, 3'b101, idx, ~seed, 3'b010, idx};
   endfunction

   function automatic axi_data_t staged_word(input fill_e fill, input logic [7:0] seed,
                                             input int idx);
      if (fill == FILL_FULL) return entry_word(seed, entry_idx_t'(idx));
      if (fill == FILL_MATCH && idx < MATCH_WORDS) return entry_word(seed, entry_idx_t'(idx));
      return '0;
   endfunction

   function automatic void table_row(input op_e op, input logic [31:0] addr,
                                     input axi_data_t data, input axi_resp_e resp);
      step_t s;
      s      = '0;
      s.op   = op;
      s.addr = addr;
      s.data = data;
      s.resp = resp;
      steps.push_back(s);
   endfunction

   function automatic void request_row(input int count, input tbl_addr_t addr,
                                       input fill_e fill, input logic [7:0] seed,
                                       input logic exp_wr, input logic exp_stats_en);
      step_t s;
      s              = '0;
      s.op           = OP_CHECK_REQ;
      s.addr         = {16'h0000, addr};
      s.data         = {24'h000000, seed};
      s.fill         = fill;
      s.exp_wr       = exp_wr;
      s.exp_stats_en = exp_stats_en;
      s.count        = count;
      steps.push_back(s);
   endfunction

   function automatic void build_table();
      // counters, ready flag and an unmapped word after reset
      table_row(OP_READ, 32'h05, EXACT_HIT_VAL, RESP_OKAY);
      table_row(OP_READ, 32'h06, EXACT_MISS_VAL, RESP_OKAY);
      table_row(OP_READ, 32'h07, WILD_HIT_VAL, RESP_OKAY);
      table_row(OP_READ, 32'h08, WILD_MISS_VAL, RESP_OKAY);
      table_row(OP_READ, 32'h04, 32'h0000_0001, RESP_OKAY);
      table_row(OP_READ, 32'h09, 32'hBEEF_CAFE, RESP_OKAY);
      // base address keeps its low 16 bits
      table_row(OP_WRITE, 32'h00, 32'hABCD_2345, RESP_OKAY);
      table_row(OP_READ, 32'h00, 32'h0000_2345, RESP_OKAY);
      table_row(OP_WRITE, 32'h30, 32'h1234_5678, RESP_SLVERR);
      // full entry then write order
      for (int i = 0; i < 28; i++)
         table_row(OP_WRITE, 32'h10 + 32'(i), entry_word(FULL_SEED, entry_idx_t'(i)), RESP_OKAY);
      // staged match and action words do not read back
      table_row(OP_READ, 32'h10, 32'h0, RESP_OKAY);
      table_row(OP_READ, 32'h29, 32'h0, RESP_OKAY);
      table_row(OP_WRITE, 32'h01, 32'h0, RESP_OKAY);
      request_row(1, 16'h2345, FILL_FULL, FULL_SEED, 1'b1, 1'b1);
      table_row(OP_WAIT_RDY, 32'h0, 32'h0, RESP_OKAY);
      // buffer was wiped, so only the match words are set
      for (int i = 0; i < 8; i++)
         table_row(OP_WRITE, 32'h10 + 32'(i), entry_word(MATCH_SEED, entry_idx_t'(i)), RESP_OKAY);
      table_row(OP_WRITE, 32'h02, 32'h0, RESP_OKAY);
      request_row(2, 16'h2345, FILL_MATCH, MATCH_SEED, 1'b1, 1'b0);
      table_row(OP_WAIT_RDY, 32'h0, 32'h0, RESP_OKAY);
      // stats from the first write survive the modify-write
      table_row(OP_WRITE, 32'h03, 32'h0, RESP_OKAY);
      request_row(3, 16'h2345, FILL_ZERO, 8'h00, 1'b0, 1'b1);
      table_row(OP_WAIT_RDY, 32'h0, 32'h0, RESP_OKAY);
      table_row(OP_READ, 32'h2A, entry_word(FULL_SEED, 5'd26), RESP_OKAY);
      table_row(OP_READ, 32'h2B, entry_word(FULL_SEED, 5'd27), RESP_OKAY);
      // read of an unwritten table address and an order while busy
      table_row(OP_WRITE, 32'h00, 32'h0000_0077, RESP_OKAY);
      table_row(OP_WRITE, 32'h03, 32'h0, RESP_OKAY);
      table_row(OP_WRITE, 32'h01, 32'h0, RESP_OKAY);
      table_row(OP_WAIT_RDY, 32'h0, 32'h0, RESP_OKAY);
      request_row(4, 16'h0077, FILL_ZERO, 8'h00, 1'b0, 1'b1);
      table_row(OP_READ, 32'h2A, 32'h0, RESP_OKAY);
      table_row(OP_READ, 32'h2B, 32'h0, RESP_OKAY);
      table_row(OP_READ, 32'h04, 32'h0000_0001, RESP_OKAY);
   endfunction

   task automatic run_step(input step_t s);
      axi_data_t got;
      axi_resp_e resp;
      match_t    exp_match;
      match_t    exp_mask;
      action_t   exp_action;
      stats_t    exp_stats;
      case (s.op)
         OP_WRITE: begin
            write_register(s.addr, s.data, resp);
            verify_resp(resp, s.resp, $sformatf("write to %h", s.addr));
         end
         OP_READ: begin
            read_register(s.addr, got, resp);
            verify_resp(resp, s.resp, $sformatf("read of %h", s.addr));
            compare_word(got, s.data, $sformatf("register %h", s.addr));
         end
         OP_WAIT_RDY: wait_until_ready();
         default: begin
            await_request(s.count);
            if (req_count != s.count)
               fail_run($sformatf("Mismatch at %0t: model saw %0d requests, expected %0d",
                                  $time, req_count, s.count));
            for (int i = 0; i < MATCH_WORDS; i++) begin
               exp_match[i*`FH_DATA_W +: `FH_DATA_W] = staged_word(s.fill, s.data[7:0], i);
               exp_mask[i*`FH_DATA_W +: `FH_DATA_W] =
                  staged_word(s.fill, s.data[7:0], MATCH_WORDS + i);
            end
            for (int i = 0; i < ACTION_WORDS; i++)
               exp_action[i*`FH_DATA_W +: `FH_DATA_W] =
                  staged_word(s.fill, s.data[7:0], 2*MATCH_WORDS + i);
            for (int i = 0; i < STATS_WORDS; i++)
               exp_stats[i*`FH_DATA_W +: `FH_DATA_W] =
                  staged_word(s.fill, s.data[7:0], STATS_FIRST_WORD + i);
            inspect_request(s.addr[`FH_TBL_W-1:0], exp_match, exp_mask, exp_action,
                            exp_stats, s.exp_wr, s.exp_stats_en);
         end
      endcase
   endtask

   initial begin
      void'($urandom(70195));
      aresetn       = 1'b0;
      awaddr        = '0;
      awvalid       = 1'b0;
      wdata         = '0;
      wstrb         = '1;
      wvalid        = 1'b0;
      bready        = 1'b0;
      araddr        = '0;
      arvalid       = 1'b0;
      rready        = 1'b0;
      exact_hit     = EXACT_HIT_VAL;
      exact_miss    = EXACT_MISS_VAL;
      wildcard_hit  = WILD_HIT_VAL;
      wildcard_miss = WILD_MISS_VAL;
      repeat (10) @(negedge aclk);
      aresetn = 1'b1;
      @(negedge aclk);
      build_table();
      foreach (steps[i]) run_step(steps[i]);
      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

// ==== tests/flow_table_model.sv ====
`timescale 1ns/10ps

module flow_table_model
   import flow_host_pkg::*;
(
   input  logic      aclk,
   input  logic      aresetn,
   input  tbl_addr_t flow_entry_addr,
   input  match_t    flow_entry_match,
   input  match_t    flow_entry_mask,
   input  action_t   flow_entry_action,
   input  stats_t    flow_entry_stats,
   input  logic      flow_entry_wr,
   input  logic      flow_entry_stats_en,
   input  logic      flow_entry_req,
   output logic      flow_entry_ack,
   output logic      flow_entry_done,
   output stats_t    flow_entry_stats_in,
   // last request as the table saw it
   output int        req_count,
   output tbl_addr_t req_addr,
   output match_t    req_match,
   output match_t    req_mask,
   output action_t   req_action,
   output stats_t    req_stats,
   output logic      req_wr,
   output logic      req_stats_en
);

   stats_t stats_mem [tbl_addr_t];
   int     ack_delay;
   int     done_delay;

   initial begin
      flow_entry_ack      = 1'b0;
      flow_entry_done     = 1'b0;
      flow_entry_stats_in = '0;
      req_count           = 0;
      forever begin
         @(negedge aclk);
         if (aresetn && flow_entry_req) begin
            req_addr     = flow_entry_addr;
            req_match    = flow_entry_match;
            req_mask     = flow_entry_mask;
            req_action   = flow_entry_action;
            req_stats    = flow_entry_stats;
            req_wr       = flow_entry_wr;
            req_stats_en = flow_entry_stats_en;
            req_count    = req_count + 1;
            ack_delay    = $urandom_range(8, 1);
            done_delay   = $urandom_range(8, 1);
            repeat (ack_delay - 1) @(negedge aclk);
            flow_entry_ack = 1'b1;
            @(negedge aclk);
            flow_entry_ack = 1'b0;
            repeat (done_delay - 1) @(negedge aclk);
            // modify-write leaves the stored stats alone
            if (req_wr) begin
               if (req_stats_en) stats_mem[req_addr] = req_stats;
            end
            else if (stats_mem.exists(req_addr)) begin
               flow_entry_stats_in = stats_mem[req_addr];
            end
            else begin
               flow_entry_stats_in = '0;
            end
            flow_entry_done = 1'b1;
            @(negedge aclk);
            flow_entry_done = 1'b0;
         end
      end
   end

endmodule

// ==== verilog/flow_host_inf.sv ====
`timescale 1ns/10ps
`include "flow_host_cfg.svh"

module flow_host_inf
   import flow_host_pkg::*;
(
   input  logic                    aclk,
   input  logic                    aresetn,
   // AXI4-Lite slave
   input  logic [`FH_ADDR_W-1:0]   awaddr,
   input  logic                    awvalid,
   output logic                    awready,
   input  axi_data_t               wdata,
   input  logic [`FH_DATA_W/8-1:0] wstrb,
   input  logic                    wvalid,
   output logic                    wready,
   output axi_resp_e               bresp,
   output logic                    bvalid,
   input  logic                    bready,
   input  logic [`FH_ADDR_W-1:0]   araddr,
   input  logic                    arvalid,
   output logic                    arready,
   output axi_data_t               rdata,
   output axi_resp_e               rresp,
   output logic                    rvalid,
   input  logic                    rready,
   // flow table side
   output tbl_addr_t               flow_entry_addr,
   output match_t                  flow_entry_match,
   output match_t                  flow_entry_mask,
   output action_t                 flow_entry_action,
   output stats_t                  flow_entry_stats,
   input  stats_t                  flow_entry_stats_in,
   output logic                    flow_entry_wr,
   output logic                    flow_entry_stats_en,
   output logic                    flow_entry_req,
   input  logic                    flow_entry_ack,
   input  logic                    flow_entry_done,
   // lookup counters
   input  axi_data_t               exact_hit,
   input  axi_data_t               exact_miss,
   input  axi_data_t               wildcard_hit,
   input  axi_data_t               wildcard_miss
);

   logic   wr_done;
   logic   acc_rdy;
   stats_t stats_rd;

   reg_wr_if reg_wr ();

   axil_write_decoder axil_write_decoder_inst (
      .aclk, .aresetn, .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid,
      .wready, .bresp, .bvalid, .bready,
      .wr (reg_wr.decoder)
   );

   flow_entry_stage flow_entry_stage_inst (
      .aclk, .aresetn,
      .wr (reg_wr.stage),
      .wr_done, .flow_entry_addr, .flow_entry_match, .flow_entry_mask,
      .flow_entry_action, .flow_entry_stats
   );

   flow_table_access flow_table_access_inst (
      .aclk, .aresetn,
      .cmd (reg_wr.access),
      .flow_entry_ack, .flow_entry_done, .flow_entry_stats_in, .flow_entry_req,
      .flow_entry_wr, .flow_entry_stats_en, .wr_done, .acc_rdy, .stats_rd
   );

   axil_read_mux axil_read_mux_inst (
      .aclk, .aresetn, .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
      .exact_hit, .exact_miss, .wildcard_hit, .wildcard_miss,
      .tbl_addr (flow_entry_addr),
      .acc_rdy, .stats_rd
   );

endmodule
